// File: src/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // ------------------------------------------------------------
  // Widths and sizes
  // ------------------------------------------------------------
  localparam int dataWidth    = 16;  // Datapath and register width
  localparam int instWidth    = 32;  // Instruction word
  localparam int regCount     = 16;
  localparam int regAddrWidth = 4;   // Low 4 bits of the 5-bit reg field
  localparam int memDepth     = 64;  // Halfwords
  localparam int memAddrWidth = 6;   // Low bits of effective address
  localparam int shamtWidth   = 5;

  // Register i comes out of reset holding i * regResetStep
  localparam int regResetStep = 10;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------
  // Primary opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    opRtype = 6'b000000,
    opLh    = 6'b100001,
    opSh    = 6'b101001,
    opAddi  = 6'b001000,
    opAndi  = 6'b001100,
    opOri   = 6'b001101,
    opSlti  = 6'b001010,
    opLui   = 6'b001111
  } opcodeT;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnNor = 6'b100111,
    fnSlt = 6'b101010,
    fnSll = 6'b000000,
    fnSrl = 6'b000010
  } functT;

  // Internal ALU operation, decoder to execute
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluNor,
    aluSlt,
    aluSll,
    aluSrl,
    aluPassB  // lui, B straight through
  } aluOpT;

endpackage

`default_nettype wire

// File: src/aluCore.sv
`timescale 1ns/10ps
`default_nettype none

module aluCore (
  input  wire logic [cpuPkg::dataWidth-1:0]   opA,
  input  wire logic [cpuPkg::dataWidth-1:0]   opB,
  input  cpuPkg::aluOpT                       aluOp,
  input  wire logic [cpuPkg::shamtWidth-1:0]  shamt,
  output logic      [cpuPkg::dataWidth-1:0]   aluResult,
  output logic                                aluOverflow
);

  localparam int msb = cpuPkg::dataWidth - 1;

  logic [cpuPkg::dataWidth-1:0] sum;
  logic [cpuPkg::dataWidth-1:0] diff;
  logic                         addOvf, subOvf;
  logic                         lessThan;

  // ------------------------------------------------------------
  // Arithmetic
  // ------------------------------------------------------------
  assign sum  = opA + opB;
  assign diff = opA - opB;

  // Same-sign operands, sign of sum flips
  assign addOvf = (opA[msb] == opB[msb]) && (sum[msb] != opA[msb]);
  // Opposite signs, result sign differs from A
  assign subOvf = (opA[msb] != opB[msb]) && (diff[msb] != opA[msb]);

  assign lessThan = opA < opB;  // Unsigned compare

  always_comb begin
    case (aluOp)
      cpuPkg::aluAdd:   aluResult = sum;
      cpuPkg::aluSub:   aluResult = diff;
      cpuPkg::aluAnd:   aluResult = opA & opB;
      cpuPkg::aluOr:    aluResult = opA | opB;
      cpuPkg::aluNor:   aluResult = ~(opA | opB);
      cpuPkg::aluSlt:   aluResult = {{msb{1'b0}}, lessThan};
      cpuPkg::aluSll:   aluResult = opB << shamt;  // Logical, B operand
      cpuPkg::aluSrl:   aluResult = opB >> shamt;
      cpuPkg::aluPassB: aluResult = opB;
      default:          aluResult = '0;
    endcase
  end

  // Flag only meaningful for add and sub
  always_comb begin
    case (aluOp)
      cpuPkg::aluAdd: aluOverflow = addOvf;
      cpuPkg::aluSub: aluOverflow = subOvf;
      default:        aluOverflow = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  wire logic                              clk,
  input  wire logic                              arstN,
  input  wire logic [cpuPkg::regAddrWidth-1:0]   rs,
  input  wire logic [cpuPkg::regAddrWidth-1:0]   rt,
  output logic      [cpuPkg::dataWidth-1:0]      rdA,
  output logic      [cpuPkg::dataWidth-1:0]      rdB,
  input  wire logic                              wrEn,
  input  wire logic [cpuPkg::regAddrWidth-1:0]   wrAddr,
  input  wire logic [cpuPkg::dataWidth-1:0]      wrData
);

  logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      // Preload i * step, reg 0 lands on zero
      for (int i = 0; i < cpuPkg::regCount; i++) begin
        regs[i] <= cpuPkg::dataWidth'(i * cpuPkg::regResetStep);
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;  // r0 stays hardwired
    end
  end

  // Read ports, combinational
  assign rdA = regs[rs];
  assign rdB = regs[rt];

endmodule

`default_nettype wire

// File: src/dataMem.sv
`timescale 1ns/10ps
`default_nettype none

module dataMem (
  input  wire logic                              clk,
  input  wire logic                              arstN,
  input  wire logic [cpuPkg::memAddrWidth-1:0]   memAddr,
  input  wire logic [cpuPkg::dataWidth-1:0]      memWrData,
  input  wire logic                              memWe,
  output logic      [cpuPkg::dataWidth-1:0]      memRdData
);

  logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memDepth];

  // Halfword array, cleared on reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < cpuPkg::memDepth; i++) begin
        mem[i] <= '0;
      end
    end else if (memWe) begin
      mem[memAddr] <= memWrData;  // sh
    end
  end

  assign memRdData = mem[memAddr];  // Same-cycle read for lh

endmodule

`default_nettype wire

// File: src/instDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instDecoder (
  input  wire logic                              clk,
  input  wire logic                              arstN,
  input  wire logic [cpuPkg::instWidth-1:0]      inst,
  input  wire logic                              instValid,
  output cpuPkg::aluOpT                          decAluOp,
  output logic                                   decValid,
  output logic                                   decUseImm,
  output logic      [cpuPkg::dataWidth-1:0]      decImm,
  output logic      [cpuPkg::regAddrWidth-1:0]   decRs,
  output logic      [cpuPkg::regAddrWidth-1:0]   decRt,
  output logic      [cpuPkg::regAddrWidth-1:0]   decRd,
  output logic      [cpuPkg::shamtWidth-1:0]     decShamt,
  output logic                                   decRegWrite,
  output logic                                   decDestIsRd,
  output logic                                   decMemRead,
  output logic                                   decMemWrite,
  output logic                                   decIllegal,
  output logic                                   decCheckOvf
);

  logic [5:0] opcode;
  logic [5:0] funct;

  cpuPkg::aluOpT aluOp;
  logic useImm, regWrite, destIsRd, memRead, memWrite, illegalOp, checkOvf;

  assign opcode = inst[31:26];
  assign funct  = inst[5:0];

  // ------------------------------------------------------------
  // Control table
  // ------------------------------------------------------------
  always_comb begin
    aluOp     = cpuPkg::aluAdd;  // Defaults, also the lh/sh address add
    useImm    = 1'b0;
    regWrite  = 1'b0;
    destIsRd  = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    illegalOp = 1'b0;
    checkOvf  = 1'b0;
    case (opcode)
      cpuPkg::opRtype: begin
        regWrite = 1'b1;
        destIsRd = 1'b1;
        case (funct)
          cpuPkg::fnAdd: begin
            aluOp    = cpuPkg::aluAdd;
            checkOvf = 1'b1;
          end
          cpuPkg::fnSub: begin
            aluOp    = cpuPkg::aluSub;
            checkOvf = 1'b1;
          end
          cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
          cpuPkg::fnOr:  aluOp = cpuPkg::aluOr;
          cpuPkg::fnNor: aluOp = cpuPkg::aluNor;
          cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
          cpuPkg::fnSll: aluOp = cpuPkg::aluSll;  // Shifts rt by shamt
          cpuPkg::fnSrl: aluOp = cpuPkg::aluSrl;
          default: begin
            illegalOp = 1'b1;  // Unknown funct, no writes
            regWrite  = 1'b0;
            destIsRd  = 1'b0;
          end
        endcase
      end
      cpuPkg::opLh: begin
        useImm   = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      cpuPkg::opSh: begin
        useImm   = 1'b1;
        memWrite = 1'b1;  // rt goes to memory
      end
      cpuPkg::opAddi: begin
        useImm   = 1'b1;
        regWrite = 1'b1;
        checkOvf = 1'b1;
      end
      cpuPkg::opAndi: begin
        aluOp    = cpuPkg::aluAnd;
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      cpuPkg::opOri: begin
        aluOp    = cpuPkg::aluOr;
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      cpuPkg::opSlti: begin
        aluOp    = cpuPkg::aluSlt;
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      cpuPkg::opLui: begin
        aluOp    = cpuPkg::aluPassB;  // 16-bit immediate as is
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      default: illegalOp = 1'b1;
    endcase
  end

  // ------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decValid    <= 1'b0;
      decRegWrite <= 1'b0;
      decMemWrite <= 1'b0;
      decMemRead  <= 1'b0;
      decIllegal  <= 1'b0;
      decCheckOvf <= 1'b0;
    end else begin
      decValid <= instValid;  // One-cycle strobe follows the word
      if (instValid) begin
        decRegWrite <= regWrite;
        decMemWrite <= memWrite;
        decMemRead  <= memRead;
        decIllegal  <= illegalOp;
        decCheckOvf <= checkOvf;
      end
    end
  end

  // Operand fields
  always_ff @(posedge clk) begin
    if (instValid) begin
      decAluOp    <= aluOp;
      decUseImm   <= useImm;
      decDestIsRd <= destIsRd;
      decImm      <= inst[15:0];
      decRs       <= inst[24:21];  // Bit 25 dropped, 16 regs
      decRt       <= inst[19:16];
      decRd       <= inst[14:11];
      decShamt    <= inst[10:6];
    end
  end

endmodule

`default_nettype wire

// File: src/execStage.sv
`timescale 1ns/10ps
`default_nettype none

module execStage (
  input  wire logic                              clk,
  input  wire logic                              arstN,
  input  wire logic                              decValid,
  input  cpuPkg::aluOpT                          decAluOp,
  input  wire logic                              decUseImm,
  input  wire logic [cpuPkg::dataWidth-1:0]      decImm,
  input  wire logic [cpuPkg::regAddrWidth-1:0]   decRs,
  input  wire logic [cpuPkg::regAddrWidth-1:0]   decRt,
  input  wire logic [cpuPkg::regAddrWidth-1:0]   decRd,
  input  wire logic [cpuPkg::shamtWidth-1:0]     decShamt,
  input  wire logic                              decRegWrite,
  input  wire logic                              decDestIsRd,
  input  wire logic                              decMemRead,
  input  wire logic                              decMemWrite,
  input  wire logic                              decIllegal,
  input  wire logic                              decCheckOvf,
  output logic                                   resultValid,
  output logic      [cpuPkg::dataWidth-1:0]      result,
  output logic                                   overflow,
  output logic                                   illegal
);

  logic [cpuPkg::dataWidth-1:0]    rdA, rdB;
  logic [cpuPkg::dataWidth-1:0]    opB;
  logic [cpuPkg::dataWidth-1:0]    aluResult;
  logic                            aluOverflow;
  logic [cpuPkg::dataWidth-1:0]    memRdData;
  logic [cpuPkg::dataWidth-1:0]    wbData;
  logic [cpuPkg::regAddrWidth-1:0] wrAddr;
  logic                            wrEn, memWe;

  assign opB    = decUseImm ? decImm : rdB;             // Immediate or rt
  assign wbData = decMemRead ? memRdData : aluResult;   // lh takes memory
  assign wrAddr = decDestIsRd ? decRd : decRt;          // rd for R-type
  assign wrEn   = decValid & decRegWrite;
  assign memWe  = decValid & decMemWrite;

  // ------------------------------------------------------------
  // Datapath blocks
  // ------------------------------------------------------------
  regFile regs (
    .clk(clk), .arstN(arstN),
    .rs(decRs), .rt(decRt), .rdA(rdA), .rdB(rdB),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wbData)
  );

  aluCore alu (
    .opA(rdA), .opB(opB), .aluOp(decAluOp), .shamt(decShamt),
    .aluResult(aluResult), .aluOverflow(aluOverflow)
  );

  dataMem mem (
    .clk(clk), .arstN(arstN),
    .memAddr(aluResult[cpuPkg::memAddrWidth-1:0]),  // Halfword index
    .memWrData(rdB), .memWe(memWe), .memRdData(memRdData)
  );

  // Status flags
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resultValid <= 1'b0;
      overflow    <= 1'b0;
      illegal     <= 1'b0;
    end else begin
      resultValid <= decValid;
      if (decValid) begin
        overflow <= decCheckOvf & aluOverflow;  // Still written back
        illegal  <= decIllegal;
      end
    end
  end

  // Result, zero for an illegal word
  always_ff @(posedge clk) begin
    if (decValid) result <= decIllegal ? '0 : wbData;
  end

endmodule

`default_nettype wire

// File: src/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop (
  input  wire logic                          clk,
  input  wire logic                          arstN,
  input  wire logic [cpuPkg::instWidth-1:0]  inst,
  input  wire logic                          instValid,
  output logic                               resultValid,
  output logic      [cpuPkg::dataWidth-1:0]  result,
  output logic                               overflow,
  output logic                               illegal
);

  // ------------------------------------------------------------
  // Decode to execute
  // ------------------------------------------------------------
  cpuPkg::aluOpT                     decAluOp;
  logic                              decValid, decUseImm;
  logic [cpuPkg::dataWidth-1:0]      decImm;
  logic [cpuPkg::regAddrWidth-1:0]   decRs, decRt, decRd;
  logic [cpuPkg::shamtWidth-1:0]     decShamt;
  logic                              decRegWrite, decDestIsRd;
  logic                              decMemRead, decMemWrite;
  logic                              decIllegal, decCheckOvf;

  instDecoder dec (
    .clk(clk), .arstN(arstN), .inst(inst), .instValid(instValid),
    .decValid(decValid), .decAluOp(decAluOp), .decUseImm(decUseImm),
    .decImm(decImm), .decRs(decRs), .decRt(decRt), .decRd(decRd),
    .decShamt(decShamt), .decRegWrite(decRegWrite), .decDestIsRd(decDestIsRd),
    .decMemRead(decMemRead), .decMemWrite(decMemWrite),
    .decIllegal(decIllegal), .decCheckOvf(decCheckOvf)
  );

  execStage exec (
    .clk(clk), .arstN(arstN),
    .decValid(decValid), .decAluOp(decAluOp), .decUseImm(decUseImm),
    .decImm(decImm), .decRs(decRs), .decRt(decRt), .decRd(decRd),
    .decShamt(decShamt), .decRegWrite(decRegWrite), .decDestIsRd(decDestIsRd),
    .decMemRead(decMemRead), .decMemWrite(decMemWrite),
    .decIllegal(decIllegal), .decCheckOvf(decCheckOvf),
    .resultValid(resultValid), .result(result),
    .overflow(overflow), .illegal(illegal)
  );

endmodule

`default_nettype wire

// File: bench/tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic arstN
);

  localparam int halfPeriod  = 2;  // 4 ns period
  localparam int resetCycles = 3;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // Reset released just after an edge
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 arstN = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tbModel.svh
`ifndef tbModelSvh
`define tbModelSvh

// ------------------------------------------------------------
// Datapath model, state and instruction semantics
// ------------------------------------------------------------
logic [cpuPkg::dataWidth-1:0] mdlRegs [cpuPkg::regCount];
logic [cpuPkg::dataWidth-1:0] mdlMem  [cpuPkg::memDepth];

task automatic modelReset();
  for (int i = 0; i < cpuPkg::regCount; i++) begin
    mdlRegs[i] = 16'(i * 10);  // Register i holds 10 * i
  end
  for (int i = 0; i < cpuPkg::memDepth; i++) begin
    mdlMem[i] = '0;
  end
endtask

// Applies one word in program order, returns what the DUT should report
function automatic void modelApply(input logic [31:0] word, output logic [15:0] res,
                                   output logic ovf, output logic ill);
  logic [5:0]  op;
  logic [5:0]  fn;
  logic [3:0]  rs, rt, rd, dst;
  logic [4:0]  sh;
  logic [15:0] imm, a, b, addr;
  logic        wr;
  op   = word[31:26];
  fn   = word[5:0];
  rs   = word[24:21];  // Top bit of each reg field ignored
  rt   = word[19:16];
  rd   = word[14:11];
  sh   = word[10:6];
  imm  = word[15:0];
  a    = mdlRegs[rs];
  b    = mdlRegs[rt];
  addr = a + imm;      // Also the addi sum
  res  = '0;
  ovf  = 1'b0;
  ill  = 1'b0;
  wr   = 1'b1;
  dst  = rt;
  case (op)
    cpuPkg::opRtype: begin
      dst = rd;
      case (fn)
        cpuPkg::fnAdd: begin
          res = a + b;
          ovf = (a[15] == b[15]) && (res[15] != a[15]);
        end
        cpuPkg::fnSub: begin
          res = a - b;
          ovf = (a[15] != b[15]) && (res[15] != a[15]);
        end
        cpuPkg::fnAnd: res = a & b;
        cpuPkg::fnOr:  res = a | b;
        cpuPkg::fnNor: res = ~(a | b);
        cpuPkg::fnSlt: res = {15'd0, a < b};                  // Unsigned
        cpuPkg::fnSll: res = (sh > 5'd15) ? 16'd0 : b << sh;  // Shifts rt
        cpuPkg::fnSrl: res = (sh > 5'd15) ? 16'd0 : b >> sh;
        default:       ill = 1'b1;
      endcase
    end
    cpuPkg::opLh: res = mdlMem[addr[5:0]];
    cpuPkg::opSh: begin
      res = addr;  // Reports the effective address
      wr  = 1'b0;
      mdlMem[addr[5:0]] = b;
    end
    cpuPkg::opAddi: begin
      res = addr;
      ovf = (a[15] == imm[15]) && (res[15] != a[15]);
    end
    cpuPkg::opAndi: res = a & imm;
    cpuPkg::opOri:  res = a | imm;
    cpuPkg::opSlti: res = {15'd0, a < imm};
    cpuPkg::opLui:  res = imm;
    default:        ill = 1'b1;
  endcase
  if (ill) begin
    res = '0;  // Illegal words report zero and write nothing
    wr  = 1'b0;
  end
  if (wr && dst != 4'd0) begin
    mdlRegs[dst] = res;  // r0 stays zero
  end
endfunction

`endif

// File: bench/tbCpu.sv
`timescale 1ns/10ps
`default_nettype none

module tbCpu;

  localparam int drainTimeout = 64;  // Cycles
  localparam int resetTimeout = 20;

  logic        clk, arstN;
  logic [31:0] inst;
  logic        instValid;
  logic        resultValid, overflow, illegal;
  logic [15:0] result;

  logic [15:0] lfsrState  = 16'd38332;
  int          cycleCount = 0;
  int          checkCount = 0;
  int          errorCount = 0;
  bit          timedOut   = 1'b0;

  // Expected responses, oldest first
  logic [15:0] expRes   [$];
  logic        expOvf   [$];
  logic        expIll   [$];
  int          expCycle [$];

  `include "tbModel.svh"

  tbClock clkGen (.clk(clk), .arstN(arstN));

  cpuTop uut (
    .clk(clk), .arstN(arstN), .inst(inst), .instValid(instValid),
    .resultValid(resultValid), .result(result),
    .overflow(overflow), .illegal(illegal)
  );

  always @(posedge clk) cycleCount <= cycleCount + 1;

  // ------------------------------------------------------------
  // Random source
  // ------------------------------------------------------------
  function automatic logic nextBit();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) lfsrState = lfsrState ^ 16'hB400;  // x^16+x^14+x^13+x^11+1
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], nextBit()};
    end
    return v;
  endfunction

  function automatic logic [5:0] opcodeAt(input logic [2:0] idx);
    case (idx)
      3'd0:    return cpuPkg::opRtype;
      3'd1:    return cpuPkg::opLh;
      3'd2:    return cpuPkg::opSh;
      3'd3:    return cpuPkg::opAddi;
      3'd4:    return cpuPkg::opAndi;
      3'd5:    return cpuPkg::opOri;
      3'd6:    return cpuPkg::opSlti;
      default: return cpuPkg::opLui;
    endcase
  endfunction

  function automatic logic [5:0] functAt(input logic [2:0] idx);
    case (idx)
      3'd0:    return cpuPkg::fnAdd;
      3'd1:    return cpuPkg::fnSub;
      3'd2:    return cpuPkg::fnAnd;
      3'd3:    return cpuPkg::fnOr;
      3'd4:    return cpuPkg::fnNor;
      3'd5:    return cpuPkg::fnSlt;
      3'd6:    return cpuPkg::fnSll;
      default: return cpuPkg::fnSrl;
    endcase
  endfunction

  function automatic logic [5:0] itypeAt(input logic [2:0] idx);
    case (idx)
      3'd0, 3'd5: return cpuPkg::opAddi;  // Biased toward addi for overflow
      3'd1, 3'd6: return cpuPkg::opAndi;
      3'd2, 3'd7: return cpuPkg::opOri;
      3'd3:       return cpuPkg::opSlti;
      default:    return cpuPkg::opLui;
    endcase
  endfunction

  function automatic bit isLegalOp(input logic [5:0] op);
    for (int i = 0; i < 8; i++) begin
      if (op == opcodeAt(3'(i))) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic bit isLegalFunct(input logic [5:0] fn);
    for (int i = 0; i < 8; i++) begin
      if (fn == functAt(3'(i))) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [3:0] rd,
                                        input logic [3:0] rs, input logic [3:0] rt,
                                        input logic [4:0] sh);
    return {6'b000000, 1'b0, rs, 1'b0, rt, 1'b0, rd, sh, fn};
  endfunction

  function automatic logic [31:0] iWord(input logic [5:0] op, input logic [3:0] rt,
                                        input logic [3:0] rs, input logic [15:0] imm);
    return {op, 1'b0, rs, 1'b0, rt, imm};
  endfunction

  // Any legal opcode, 1 in 16 illegal; reg fields keep their spare top bit
  function automatic logic [31:0] randomInst();
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [25:0] body;
    if (randBits(4) == 32'd0) begin
      op = 6'(randBits(6));
      while (isLegalOp(op)) op = 6'(randBits(6));
    end else begin
      op = opcodeAt(3'(randBits(3)));
    end
    body = 26'(randBits(26));
    fn   = functAt(3'(randBits(3)));
    if (op == cpuPkg::opRtype) body[5:0] = fn;
    return {op, body};
  endfunction

  // ------------------------------------------------------------
  // Driving
  // ------------------------------------------------------------
  task automatic sendInst(input logic [31:0] word);
    logic [15:0] r;
    logic        o, il;
    @(posedge clk);
    #1;
    inst      = word;
    instValid = 1'b1;
    modelApply(word, r, o, il);
    expRes.push_back(r);
    expOvf.push_back(o);
    expIll.push_back(il);
    expCycle.push_back(cycleCount + 2);  // Two edges to resultValid
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #1;
    instValid = 1'b0;
    inst      = randBits(32);  // Junk while idle
  endtask

  task automatic sendGap(input logic [31:0] word);
    sendInst(word);
    if (nextBit()) idleCycle();
  endtask

  task automatic waitDrain();
    int n;
    idleCycle();
    n = 0;
    while (expRes.size() > 0 && n < drainTimeout) begin
      @(posedge clk);
      n++;
    end
    if (expRes.size() > 0) begin
      $display("Timed out after %0d cycles with %0d results still missing", n, expRes.size());
      timedOut = 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // Response checker
  // ------------------------------------------------------------
  always @(negedge clk) begin
    logic [15:0] eRes;
    logic        eOvf, eIll;
    int          eCyc;
    if (arstN && resultValid) begin
      assert (expRes.size() > 0) else begin
        $display("Result pulse at %0t with no instruction outstanding", $time);
        errorCount++;
      end
      if (expRes.size() > 0) begin
        eRes = expRes.pop_front();
        eOvf = expOvf.pop_front();
        eIll = expIll.pop_front();
        eCyc = expCycle.pop_front();
        checkCount++;
        assert (cycleCount == eCyc) else begin
          $display("Fail at %0t: result came in cycle %0d, expected %0d", $time, cycleCount,
                   eCyc);
          errorCount++;
        end
        assert (result === eRes) else begin
          $display("Fail at %0t: result %h, expected %h", $time, result, eRes);
          errorCount++;
        end
        assert (overflow === eOvf) else begin
          $display("Fail at %0t: overflow %b, expected %b", $time, overflow, eOvf);
          errorCount++;
        end
        assert (illegal === eIll) else begin
          $display("Fail at %0t: illegal %b, expected %b", $time, illegal, eIll);
          errorCount++;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic testReset();
    checkCount++;
    assert (resultValid === 1'b0) else begin
      $display("Fail at %0t: resultValid %b after reset, expected 0", $time, resultValid);
      errorCount++;
    end
    for (int i = 0; i < 16; i++) begin
      sendInst(iWord(cpuPkg::opOri, 4'(i), 4'(i), 16'h0000));  // Reads back 10 * i
    end
    for (int i = 0; i < 16; i++) begin
      sendInst(iWord(cpuPkg::opLh, 4'd0, 4'd0, 16'(randBits(16))));
    end
    waitDrain();
  endtask

  task automatic testRtype();
    logic [5:0] fn;
    logic [3:0] rd, rs, rt;
    logic [4:0] sh;
    for (int i = 1; i < 16; i++) begin
      sendGap(iWord(cpuPkg::opLui, 4'(i), 4'd0, 16'(randBits(16))));  // Wide operands
    end
    for (int i = 0; i < 150; i++) begin
      fn = functAt(3'(randBits(3)));
      rd = 4'(randBits(4));
      rs = 4'(randBits(4));
      rt = 4'(randBits(4));
      sh = 5'(randBits(5));
      sendGap(rWord(fn, rd, rs, rt, sh));
    end
    waitDrain();
  endtask

  task automatic testItype();
    logic [5:0] op;
    logic [3:0] rt, rs;
    for (int i = 0; i < 150; i++) begin
      op = itypeAt(3'(randBits(3)));
      rt = 4'(randBits(4));
      rs = 4'(randBits(4));
      sendGap(iWord(op, rt, rs, 16'(randBits(16))));
    end
    sendInst(iWord(cpuPkg::opAddi, 4'd0, 4'd0, 16'h1234));  // Write to r0 dropped
    sendInst(iWord(cpuPkg::opOri, 4'd5, 4'd0, 16'h0000));
    waitDrain();
  endtask

  task automatic testMemory();
    logic [15:0] addr;
    for (int i = 0; i < 40; i++) begin
      addr = 16'(randBits(16));
      sendGap(iWord(cpuPkg::opSh, 4'(randBits(4)), 4'd0, addr));
      addr[15:6] = 10'(randBits(10));  // Same halfword, other upper bits
      sendGap(iWord(cpuPkg::opLh, 4'(randBits(4)), 4'd0, addr));
      sendGap(iWord(cpuPkg::opLh, 4'(randBits(4)), 4'(randBits(4)), 16'(randBits(16))));
    end
    waitDrain();
  endtask

  task automatic testIllegal();
    logic [31:0] word;
    logic [5:0]  fn;
    for (int i = 0; i < 20; i++) begin
      word = randBits(32);
      while (isLegalOp(word[31:26])) word[31:26] = 6'(randBits(6));
      sendGap(word);
      fn = 6'(randBits(6));
      while (isLegalFunct(fn)) fn = 6'(randBits(6));
      sendGap(rWord(fn, 4'(randBits(4)), 4'(randBits(4)), 4'(randBits(4)), 5'd0));
    end
    // Full readback, registers then memory
    for (int i = 0; i < 16; i++) begin
      sendInst(iWord(cpuPkg::opOri, 4'(i), 4'(i), 16'h0000));
    end
    for (int i = 0; i < cpuPkg::memDepth; i++) begin
      sendInst(iWord(cpuPkg::opLh, 4'd0, 4'd0, 16'(i)));
    end
    waitDrain();
  endtask

  task automatic testPipeline();
    logic [31:0] word;
    logic [3:0]  prevDst;
    prevDst = 4'd1;
    for (int i = 0; i < 100; i++) begin
      word = randomInst();
      word[25:21] = {1'b0, prevDst};  // Source is the previous destination
      prevDst = (word[31:26] == cpuPkg::opRtype) ? word[14:11] : word[19:16];
      sendInst(word);
    end
    waitDrain();
  endtask

  task automatic runTest(input int id);
    int    checks0;
    int    errors0;
    string name;
    checks0 = checkCount;
    errors0 = errorCount;
    case (id)
      1: begin
        name = "reset state";
        testReset();
      end
      2: begin
        name = "R-type operations";
        testRtype();
      end
      3: begin
        name = "I-type operations";
        testItype();
      end
      4: begin
        name = "store then load";
        testMemory();
      end
      5: begin
        name = "illegal instructions";
        testIllegal();
      end
      default: begin
        name = "back-to-back pipelining";
        testPipeline();
      end
    endcase
    $display("Test %0d, %s: %0d checks, %0d errors", id, name, checkCount - checks0,
             errorCount - errors0);
  endtask

  initial begin
    int n;
    inst      = '0;
    instValid = 1'b0;
    modelReset();
    n = 0;
    while (arstN !== 1'b1 && n < resetTimeout) begin
      @(posedge clk);
      n++;
    end
    if (arstN !== 1'b1) begin
      $display("Reset was never released");
      timedOut = 1'b1;
    end
    for (int t = 1; t <= 6 && !timedOut; t++) begin
      runTest(t);
    end
    $display("Totals: %0d checks, %0d errors, timeout %0d", checkCount, errorCount, timedOut);
    if (errorCount == 0 && !timedOut) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
src/cpuPkg.sv
src/aluCore.sv
src/regFile.sv
src/dataMem.sv
src/instDecoder.sv
src/execStage.sv
src/cpuTop.sv
bench/tbClock.sv
bench/tbCpu.sv

// File: Makefile
# Verilator flow for the 16-bit datapath and its testbench
VERILATOR  ?= verilator
TOP        ?= tbCpu
RTL_TOP    ?= cpuTop
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing
# Add -Wall here for the stricter style checks
LINT_FLAGS ?=
PASS_TEXT  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the search for the pass line, not from the binary
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
